/* fe_pkg.sv */
`default_nettype none

package fe_pkg;

    // datapath widths.
    localparam int xlen = 32;

    // instruction buffer geometry.
    localparam int ibuf_depth = 8;
    localparam int ibuf_ptr_w = 3;
    localparam int ibuf_cnt_w = 4;

    // ready stays high up to this occupancy so one two-wide write still fits.
    localparam int ibuf_accept_max = 4;

    // filler word for an exception entry.
    localparam logic [xlen-1:0] nop_inst = 32'h0340_0000;

    // major opcode of a conditional branch, offset in bits 15:0.
    localparam logic [5:0] br_opcode = 6'h04;

    typedef enum logic [1:0] {
        exc_none             = 2'd0,
        exc_fetch_misaligned = 2'd1
    } exception_t;

endpackage

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          redirect,
    input  wire  [fe_pkg::xlen-1:0]      redirect_pc,

    output logic [fe_pkg::xlen-1:0]      fetch_addr,
    input  wire  [fe_pkg::xlen-1:0]      fetch_word1,
    input  wire  [fe_pkg::xlen-1:0]      fetch_word2,

    input  wire                          push_ready,
    output logic [1:0]                   push_size,
    output logic [fe_pkg::xlen-1:0]      push_pc1,
    output logic [fe_pkg::xlen-1:0]      push_inst1,
    output logic                         push_pred_taken1,
    output logic [fe_pkg::xlen-1:0]      push_pred_target1,
    output fe_pkg::exception_t           push_exc1,
    output logic [fe_pkg::xlen-1:0]      push_pc2,
    output logic [fe_pkg::xlen-1:0]      push_inst2,
    output logic                         push_pred_taken2,
    output logic [fe_pkg::xlen-1:0]      push_pred_target2,
    output fe_pkg::exception_t           push_exc2
);

    logic [fe_pkg::xlen-1:0] pc;
    logic [fe_pkg::xlen-1:0] pc_next;
    logic                    halt;
    logic                    misaligned;
    logic                    taken1;
    logic                    taken2;
    logic [fe_pkg::xlen-1:0] target1;
    logic [fe_pkg::xlen-1:0] target2;

    // static rule: backward branches are taken.
    function automatic logic pred_taken(input logic [fe_pkg::xlen-1:0] w);
        return (w[31:26] == fe_pkg::br_opcode) && w[15];
    endfunction

    function automatic logic [fe_pkg::xlen-1:0] br_target(
        input logic [fe_pkg::xlen-1:0] bpc,
        input logic [fe_pkg::xlen-1:0] w
    );
        return bpc + 32'd4 + {{(fe_pkg::xlen-18){w[15]}}, w[15:0], 2'b00};
    endfunction

    assign fetch_addr = pc;
    assign misaligned = pc[1:0] != 2'b00;

    assign taken1  = pred_taken(fetch_word1);
    assign taken2  = pred_taken(fetch_word2);
    assign target1 = br_target(pc, fetch_word1);
    assign target2 = br_target(pc + 32'd4, fetch_word2);

    always_comb begin
        if (redirect || halt || !push_ready) begin
            push_size = 2'd0;
        end else if (misaligned || taken1) begin
            push_size = 2'd1; // second word dropped.
        end else begin
            push_size = 2'd2;
        end
    end

    assign push_pc1          = pc;
    assign push_inst1        = misaligned ? fe_pkg::nop_inst : fetch_word1;
    assign push_pred_taken1  = taken1 && !misaligned;
    assign push_pred_target1 = target1;
    assign push_exc1         = misaligned ? fe_pkg::exc_fetch_misaligned : fe_pkg::exc_none;

    assign push_pc2          = pc + 32'd4;
    assign push_inst2        = fetch_word2;
    assign push_pred_taken2  = taken2;
    assign push_pred_target2 = target2;
    assign push_exc2         = fe_pkg::exc_none;

    always_comb begin
        pc_next = pc;
        if (push_size != 2'd0 && !misaligned) begin
            if (taken1) begin
                pc_next = target1;
            end else if (taken2) begin
                pc_next = target2;
            end else begin
                pc_next = pc + 32'd8;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc   <= reset_pc;
            halt <= 1'b0;
        end else if (redirect) begin
            pc   <= redirect_pc;
            halt <= 1'b0;
        end else begin
            pc <= pc_next;
            if (push_size != 2'd0 && misaligned) begin
                halt <= 1'b1; // sticky until the next redirect.
            end
        end
    end

    // one exception entry, then fetch stays quiet.
    a_halt_after_exc: assert property (@(posedge clk) disable iff (rst)
        push_size != 2'd0 && misaligned |=> push_size == 2'd0);

endmodule

`default_nettype wire

/* ibuf.sv */
`timescale 1ns/1ps
`default_nettype none

module ibuf (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          flush,

    input  wire  [1:0]                   push_size,
    output logic                         push_ready,
    input  wire  [fe_pkg::xlen-1:0]      push_pc1,
    input  wire  [fe_pkg::xlen-1:0]      push_inst1,
    input  wire                          push_pred_taken1,
    input  wire  [fe_pkg::xlen-1:0]      push_pred_target1,
    input  wire  fe_pkg::exception_t     push_exc1,
    input  wire  [fe_pkg::xlen-1:0]      push_pc2,
    input  wire  [fe_pkg::xlen-1:0]      push_inst2,
    input  wire                          push_pred_taken2,
    input  wire  [fe_pkg::xlen-1:0]      push_pred_target2,
    input  wire  fe_pkg::exception_t     push_exc2,

    output logic                         head_valid1,
    output logic [fe_pkg::xlen-1:0]      head_pc1,
    output logic [fe_pkg::xlen-1:0]      head_inst1,
    output logic                         head_pred_taken1,
    output logic [fe_pkg::xlen-1:0]      head_pred_target1,
    output fe_pkg::exception_t           head_exc1,
    output logic                         head_valid2,
    output logic [fe_pkg::xlen-1:0]      head_pc2,
    output logic [fe_pkg::xlen-1:0]      head_inst2,
    output logic                         head_pred_taken2,
    output logic [fe_pkg::xlen-1:0]      head_pred_target2,
    output fe_pkg::exception_t           head_exc2,

    input  wire  [1:0]                   consume
);

    logic [fe_pkg::xlen-1:0] pc_mem     [fe_pkg::ibuf_depth];
    logic [fe_pkg::xlen-1:0] inst_mem   [fe_pkg::ibuf_depth];
    logic                    taken_mem  [fe_pkg::ibuf_depth];
    logic [fe_pkg::xlen-1:0] target_mem [fe_pkg::ibuf_depth];
    fe_pkg::exception_t      exc_mem    [fe_pkg::ibuf_depth];

    logic [fe_pkg::ibuf_ptr_w-1:0] head;
    logic [fe_pkg::ibuf_ptr_w-1:0] tail;
    logic [fe_pkg::ibuf_ptr_w-1:0] head_p1;
    logic [fe_pkg::ibuf_ptr_w-1:0] tail_p1;
    logic [fe_pkg::ibuf_cnt_w-1:0] count;
    logic [fe_pkg::ibuf_cnt_w-1:0] push_cnt;
    logic [fe_pkg::ibuf_cnt_w-1:0] consume_cnt;

    assign head_p1     = head + {{(fe_pkg::ibuf_ptr_w-1){1'b0}}, 1'b1};
    assign tail_p1     = tail + {{(fe_pkg::ibuf_ptr_w-1){1'b0}}, 1'b1};
    assign push_cnt    = {{(fe_pkg::ibuf_cnt_w-2){1'b0}}, push_size};
    assign consume_cnt = {{(fe_pkg::ibuf_cnt_w-2){1'b0}}, consume};

    assign push_ready = int'(count) <= fe_pkg::ibuf_accept_max;

    // two oldest entries.
    assign head_valid1       = count >= {{(fe_pkg::ibuf_cnt_w-1){1'b0}}, 1'b1};
    assign head_pc1          = pc_mem[head];
    assign head_inst1        = inst_mem[head];
    assign head_pred_taken1  = taken_mem[head];
    assign head_pred_target1 = target_mem[head];
    assign head_exc1         = exc_mem[head];

    assign head_valid2       = count >= {{(fe_pkg::ibuf_cnt_w-2){1'b0}}, 2'd2};
    assign head_pc2          = pc_mem[head_p1];
    assign head_inst2        = inst_mem[head_p1];
    assign head_pred_taken2  = taken_mem[head_p1];
    assign head_pred_target2 = target_mem[head_p1];
    assign head_exc2         = exc_mem[head_p1];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + consume_cnt[fe_pkg::ibuf_ptr_w-1:0];
            tail  <= tail + push_cnt[fe_pkg::ibuf_ptr_w-1:0];
            count <= count + push_cnt - consume_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst && !flush) begin
            if (push_size != 2'd0) begin
                pc_mem[tail]     <= push_pc1;
                inst_mem[tail]   <= push_inst1;
                taken_mem[tail]  <= push_pred_taken1;
                target_mem[tail] <= push_pred_target1;
                exc_mem[tail]    <= push_exc1;
            end
            if (push_size == 2'd2) begin
                pc_mem[tail_p1]     <= push_pc2;
                inst_mem[tail_p1]   <= push_inst2;
                taken_mem[tail_p1]  <= push_pred_taken2;
                target_mem[tail_p1] <= push_pred_target2;
                exc_mem[tail_p1]    <= push_exc2;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        int'(count) <= fe_pkg::ibuf_depth);

    // issue side may only take what is there.
    a_no_underflow: assert property (@(posedge clk) disable iff (rst || flush)
        consume_cnt <= count);

endmodule

`default_nettype wire

/* issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          flush,
    input  wire  [1:0]                   issue_allow,

    input  wire                          head_valid1,
    input  wire  [fe_pkg::xlen-1:0]      head_pc1,
    input  wire  [fe_pkg::xlen-1:0]      head_inst1,
    input  wire                          head_pred_taken1,
    input  wire  [fe_pkg::xlen-1:0]      head_pred_target1,
    input  wire  fe_pkg::exception_t     head_exc1,
    input  wire                          head_valid2,
    input  wire  [fe_pkg::xlen-1:0]      head_pc2,
    input  wire  [fe_pkg::xlen-1:0]      head_inst2,
    input  wire                          head_pred_taken2,
    input  wire  [fe_pkg::xlen-1:0]      head_pred_target2,
    input  wire  fe_pkg::exception_t     head_exc2,

    output logic [1:0]                   consume,

    output logic                         out_valid1,
    output logic [fe_pkg::xlen-1:0]      out_pc1,
    output logic [fe_pkg::xlen-1:0]      out_inst1,
    output logic                         out_pred_taken1,
    output logic [fe_pkg::xlen-1:0]      out_pred_target1,
    output fe_pkg::exception_t           out_exc1,
    output logic                         out_valid2,
    output logic [fe_pkg::xlen-1:0]      out_pc2,
    output logic [fe_pkg::xlen-1:0]      out_inst2,
    output logic                         out_pred_taken2,
    output logic [fe_pkg::xlen-1:0]      out_pred_target2
);

    logic [1:0] n_valid;
    logic       has_exc;

    assign n_valid = {1'b0, head_valid1} + {1'b0, head_valid2};
    assign has_exc = (head_exc1 != fe_pkg::exc_none) || (head_exc2 != fe_pkg::exc_none);

    always_comb begin
        consume = (issue_allow < n_valid) ? issue_allow : n_valid;
        // an exception entry always goes out alone in slot 1.
        if (consume == 2'd2 && has_exc) begin
            consume = 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid1 <= 1'b0;
            out_valid2 <= 1'b0;
        end else begin
            out_valid1 <= consume != 2'd0;
            out_valid2 <= consume == 2'd2;
        end
    end

    always_ff @(posedge clk) begin
        if (consume != 2'd0) begin
            out_pc1          <= head_pc1;
            out_inst1        <= head_inst1;
            out_pred_taken1  <= head_pred_taken1;
            out_pred_target1 <= head_pred_target1;
            out_exc1         <= head_exc1;
        end
        if (consume == 2'd2) begin
            out_pc2          <= head_pc2;
            out_inst2        <= head_inst2;
            out_pred_taken2  <= head_pred_taken2;
            out_pred_target2 <= head_pred_target2;
        end
    end

    a_exc_alone: assert property (@(posedge clk) disable iff (rst)
        out_valid2 |-> out_exc1 == fe_pkg::exc_none);

endmodule

`default_nettype wire

/* frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          redirect,
    input  wire  [fe_pkg::xlen-1:0]      redirect_pc,

    output logic [fe_pkg::xlen-1:0]      fetch_addr,
    input  wire  [fe_pkg::xlen-1:0]      fetch_word1,
    input  wire  [fe_pkg::xlen-1:0]      fetch_word2,

    input  wire  [1:0]                   issue_allow,
    output logic                         out_valid1,
    output logic [fe_pkg::xlen-1:0]      out_pc1,
    output logic [fe_pkg::xlen-1:0]      out_inst1,
    output logic                         out_pred_taken1,
    output logic [fe_pkg::xlen-1:0]      out_pred_target1,
    output fe_pkg::exception_t           out_exc1,
    output logic                         out_valid2,
    output logic [fe_pkg::xlen-1:0]      out_pc2,
    output logic [fe_pkg::xlen-1:0]      out_inst2,
    output logic                         out_pred_taken2,
    output logic [fe_pkg::xlen-1:0]      out_pred_target2
);

    // fetch to buffer.
    logic [1:0]              push_size;
    logic                    push_ready;
    logic [fe_pkg::xlen-1:0] push_pc1;
    logic [fe_pkg::xlen-1:0] push_inst1;
    logic                    push_pred_taken1;
    logic [fe_pkg::xlen-1:0] push_pred_target1;
    fe_pkg::exception_t      push_exc1;
    logic [fe_pkg::xlen-1:0] push_pc2;
    logic [fe_pkg::xlen-1:0] push_inst2;
    logic                    push_pred_taken2;
    logic [fe_pkg::xlen-1:0] push_pred_target2;
    fe_pkg::exception_t      push_exc2;

    // buffer to issue.
    logic                    head_valid1;
    logic [fe_pkg::xlen-1:0] head_pc1;
    logic [fe_pkg::xlen-1:0] head_inst1;
    logic                    head_pred_taken1;
    logic [fe_pkg::xlen-1:0] head_pred_target1;
    fe_pkg::exception_t      head_exc1;
    logic                    head_valid2;
    logic [fe_pkg::xlen-1:0] head_pc2;
    logic [fe_pkg::xlen-1:0] head_inst2;
    logic                    head_pred_taken2;
    logic [fe_pkg::xlen-1:0] head_pred_target2;
    fe_pkg::exception_t      head_exc2;
    logic [1:0]              consume;

    fetch_unit #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk(clk),
        .rst(rst),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .fetch_addr(fetch_addr),
        .fetch_word1(fetch_word1),
        .fetch_word2(fetch_word2),
        .push_ready(push_ready),
        .push_size(push_size),
        .push_pc1(push_pc1),
        .push_inst1(push_inst1),
        .push_pred_taken1(push_pred_taken1),
        .push_pred_target1(push_pred_target1),
        .push_exc1(push_exc1),
        .push_pc2(push_pc2),
        .push_inst2(push_inst2),
        .push_pred_taken2(push_pred_taken2),
        .push_pred_target2(push_pred_target2),
        .push_exc2(push_exc2)
    );

    ibuf u_ibuf (
        .clk(clk),
        .rst(rst),
        .flush(redirect),
        .push_size(push_size),
        .push_ready(push_ready),
        .push_pc1(push_pc1),
        .push_inst1(push_inst1),
        .push_pred_taken1(push_pred_taken1),
        .push_pred_target1(push_pred_target1),
        .push_exc1(push_exc1),
        .push_pc2(push_pc2),
        .push_inst2(push_inst2),
        .push_pred_taken2(push_pred_taken2),
        .push_pred_target2(push_pred_target2),
        .push_exc2(push_exc2),
        .head_valid1(head_valid1),
        .head_pc1(head_pc1),
        .head_inst1(head_inst1),
        .head_pred_taken1(head_pred_taken1),
        .head_pred_target1(head_pred_target1),
        .head_exc1(head_exc1),
        .head_valid2(head_valid2),
        .head_pc2(head_pc2),
        .head_inst2(head_inst2),
        .head_pred_taken2(head_pred_taken2),
        .head_pred_target2(head_pred_target2),
        .head_exc2(head_exc2),
        .consume(consume)
    );

    issue_stage u_issue (
        .clk(clk),
        .rst(rst),
        .flush(redirect),
        .issue_allow(issue_allow),
        .head_valid1(head_valid1),
        .head_pc1(head_pc1),
        .head_inst1(head_inst1),
        .head_pred_taken1(head_pred_taken1),
        .head_pred_target1(head_pred_target1),
        .head_exc1(head_exc1),
        .head_valid2(head_valid2),
        .head_pc2(head_pc2),
        .head_inst2(head_inst2),
        .head_pred_taken2(head_pred_taken2),
        .head_pred_target2(head_pred_target2),
        .head_exc2(head_exc2),
        .consume(consume),
        .out_valid1(out_valid1),
        .out_pc1(out_pc1),
        .out_inst1(out_inst1),
        .out_pred_taken1(out_pred_taken1),
        .out_pred_target1(out_pred_target1),
        .out_exc1(out_exc1),
        .out_valid2(out_valid2),
        .out_pc2(out_pc2),
        .out_inst2(out_inst2),
        .out_pred_taken2(out_pred_taken2),
        .out_pred_target2(out_pred_target2)
    );

endmodule

`default_nettype wire

/* tb_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;

    typedef struct packed {
        logic [31:0]        pc;
        logic [31:0]        inst;
        logic               taken;
        logic [31:0]        target;
        fe_pkg::exception_t exc;
    } entry_t;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic               redirect = 1'b0;
    logic [31:0]        redirect_pc = 32'h0;
    logic [31:0]        fetch_addr;
    logic [31:0]        fetch_word1;
    logic [31:0]        fetch_word2;
    logic [1:0]         issue_allow = 2'd0;
    logic               out_valid1;
    logic [31:0]        out_pc1;
    logic [31:0]        out_inst1;
    logic               out_pred_taken1;
    logic [31:0]        out_pred_target1;
    fe_pkg::exception_t out_exc1;
    logic               out_valid2;
    logic [31:0]        out_pc2;
    logic [31:0]        out_inst2;
    logic               out_pred_taken2;
    logic [31:0]        out_pred_target2;

    entry_t      exp_q[$]; // expected issue order.
    integer      seed = 32'h8b5e;
    logic [31:0] rnd;
    int          stall_left = 0;
    int          allow_mode = 1; // 0 hold, 1 full width, 2 random.
    string       test_name = "";
    bit          collecting = 1'b0;
    bit          strict = 1'b0;
    int          got_total = 0;
    int          slot_errs = 0;
    int          base_got = 0;
    int          base_errs = 0;
    int          main_errs = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;

    frontend_top #(
        .reset_pc(32'h0000_0000)
    ) dut (
        .clk(clk),
        .rst(rst),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .fetch_addr(fetch_addr),
        .fetch_word1(fetch_word1),
        .fetch_word2(fetch_word2),
        .issue_allow(issue_allow),
        .out_valid1(out_valid1),
        .out_pc1(out_pc1),
        .out_inst1(out_inst1),
        .out_pred_taken1(out_pred_taken1),
        .out_pred_target1(out_pred_target1),
        .out_exc1(out_exc1),
        .out_valid2(out_valid2),
        .out_pc2(out_pc2),
        .out_inst2(out_inst2),
        .out_pred_taken2(out_pred_taken2),
        .out_pred_target2(out_pred_target2)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] branch_word(input logic [15:0] offset);
        return {fe_pkg::br_opcode, 10'h000, offset};
    endfunction

    // instruction memory, plain alu words except a few branches.
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        case (addr)
            32'h0000_2004: return branch_word(16'h0005); // forward, slot 2.
            32'h0000_2010: return branch_word(16'hffbb); // back to 0x1f00.
            32'h0000_1f08: return branch_word(16'h0007); // forward, slot 1.
            32'h0000_1f0c: return branch_word(16'hfffd); // back to 0x1f04.
            default:       return {6'h08, addr[25:0] ^ {20'h00000, addr[31:26]}};
        endcase
    endfunction

    assign fetch_word1 = mem_word(fetch_addr);
    assign fetch_word2 = mem_word(fetch_addr + 32'd4);

    // signed word offset of a branch.
    function automatic int branch_offset(input logic [31:0] w);
        return int'($signed(w[15:0]));
    endfunction

    function automatic logic is_backward_branch(input logic [31:0] w);
        return (w[31:26] == fe_pkg::br_opcode) && (branch_offset(w) < 0);
    endfunction

    function automatic logic [31:0] branch_target(input logic [31:0] pc, input logic [31:0] w);
        return pc + 32'd4 + 32'(branch_offset(w) * 4);
    endfunction

    function automatic void add_expected(
        input logic [31:0]        pc,
        input logic [31:0]        inst,
        input logic               taken,
        input logic [31:0]        target,
        input fe_pkg::exception_t exc
    );
        entry_t e;
        e.pc     = pc;
        e.inst   = inst;
        e.taken  = taken;
        e.target = target;
        e.exc    = exc;
        exp_q.push_back(e);
    endfunction

    // first n entries that should issue after a restart at start_pc.
    function automatic void next_fetch_stream(input logic [31:0] start_pc, input int n);
        logic [31:0] pc;
        logic [31:0] w1;
        logic [31:0] w2;
        bit          halted;
        pc = start_pc;
        halted = 1'b0;
        exp_q.delete();
        while (!halted && exp_q.size() < n) begin
            w1 = mem_word(pc);
            w2 = mem_word(pc + 32'd4);
            if (pc[1:0] != 2'b00) begin
                add_expected(pc, fe_pkg::nop_inst, 1'b0, 32'h0, fe_pkg::exc_fetch_misaligned);
                halted = 1'b1; // nothing more until a redirect.
            end else if (is_backward_branch(w1)) begin
                add_expected(pc, w1, 1'b1, branch_target(pc, w1), fe_pkg::exc_none);
                pc = branch_target(pc, w1);
            end else begin
                add_expected(pc, w1, 1'b0, 32'h0, fe_pkg::exc_none);
                add_expected(pc + 32'd4, w2, is_backward_branch(w2),
                             branch_target(pc + 32'd4, w2), fe_pkg::exc_none);
                if (is_backward_branch(w2)) begin
                    pc = branch_target(pc + 32'd4, w2);
                end else begin
                    pc = pc + 32'd8;
                end
            end
        end
        while (exp_q.size() > n) begin
            void'(exp_q.pop_back());
        end
    endfunction

    task automatic show_mismatch(
        input int          idx,
        input string       field,
        input logic [31:0] expv,
        input logic [31:0] actv
    );
        $display("** Error %s entry %0d %s: expected %h, actual %h",
                 test_name, idx, field, expv, actv);
    endtask

    task automatic check_slot(
        input logic [31:0]        pc,
        input logic [31:0]        inst,
        input logic               taken,
        input logic [31:0]        target,
        input fe_pkg::exception_t exc
    );
        int i;
        i = got_total - base_got;
        got_total++;
        if (i >= exp_q.size()) begin
            if (strict) begin
                $display("%s: entry at pc %h issued after the expected stream ended",
                         test_name, pc);
                slot_errs++;
            end
        end else begin
            if (pc !== exp_q[i].pc) begin
                show_mismatch(i, "pc", exp_q[i].pc, pc);
                slot_errs++;
            end
            if (inst !== exp_q[i].inst) begin
                show_mismatch(i, "inst", exp_q[i].inst, inst);
                slot_errs++;
            end
            if (taken !== exp_q[i].taken) begin
                show_mismatch(i, "pred_taken", {31'b0, exp_q[i].taken}, {31'b0, taken});
                slot_errs++;
            end
            if (exp_q[i].taken && target !== exp_q[i].target) begin
                show_mismatch(i, "pred_target", exp_q[i].target, target);
                slot_errs++;
            end
            if (exc !== exp_q[i].exc) begin
                show_mismatch(i, "exc", {30'b0, exp_q[i].exc}, {30'b0, exc});
                slot_errs++;
            end
        end
    endtask

    // issued slots, oldest first.
    always @(negedge clk) begin
        if (collecting && out_valid1) begin
            check_slot(out_pc1, out_inst1, out_pred_taken1, out_pred_target1, out_exc1);
        end
        if (collecting && out_valid2) begin
            if (out_exc1 != fe_pkg::exc_none) begin
                $display("%s: exception entry issued with a second entry beside it", test_name);
                slot_errs++;
            end
            check_slot(out_pc2, out_inst2, out_pred_taken2, out_pred_target2, fe_pkg::exc_none);
        end
    end

    always @(posedge clk) begin
        #1;
        rnd = $random(seed);
        if (allow_mode == 0) begin
            issue_allow = 2'd0;
        end else if (allow_mode == 1) begin
            issue_allow = 2'd2;
        end else if (stall_left > 0) begin
            stall_left--;
            issue_allow = 2'd0;
        end else if (rnd[4:0] == 5'd0) begin
            stall_left = 20; // long stall lets the buffer fill.
            issue_allow = 2'd0;
        end else begin
            issue_allow = (rnd[6:5] == 2'd3) ? 2'd2 : rnd[6:5];
        end
    end

    task automatic set_allow_mode(input int mode);
        @(negedge clk);
        allow_mode = mode;
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        @(posedge clk);
        #1;
        redirect = 1'b1;
        redirect_pc = pc;
        @(posedge clk);
        #1;
        redirect = 1'b0;
    endtask

    task automatic begin_collect(
        input string       name,
        input logic [31:0] start_pc,
        input int          n,
        input bit          strict_mode
    );
        test_name = name;
        next_fetch_stream(start_pc, n);
        base_got = got_total;
        base_errs = slot_errs;
        main_errs = 0;
        strict = strict_mode;
        collecting = 1'b1;
    endtask

    task automatic finish_test(input int limit, input int settle);
        int cycles;
        int errs;
        cycles = 0;
        while (got_total - base_got < exp_q.size() && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (got_total - base_got < exp_q.size()) begin
            $display("%s: timed out after %0d cycles with %0d of %0d entries issued",
                     test_name, cycles, got_total - base_got, exp_q.size());
            main_errs++;
        end
        repeat (settle) @(posedge clk);
        #1;
        collecting = 1'b0;
        errs = main_errs + slot_errs - base_errs;
        if (errs == 0) begin
            $display("PASS %s", test_name);
            pass_cnt++;
        end else begin
            $display("FAIL %s with %0d errors", test_name, errs);
            fail_cnt++;
        end
    endtask

    task automatic run_test(
        input string       name,
        input logic [31:0] start_pc,
        input int          n,
        input int          limit,
        input bit          strict_mode,
        input int          settle
    );
        redirect_to(start_pc);
        begin_collect(name, start_pc, n, strict_mode);
        finish_test(limit, settle);
    endtask

    initial begin
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        begin_collect("reset state", 32'h0, 16, 1'b0);
        if (out_valid1 !== 1'b0 || out_valid2 !== 1'b0) begin
            $display("reset state: an out_valid flag is not low after reset");
            main_errs++;
        end
        if (fetch_addr !== 32'h0) begin
            show_mismatch(0, "fetch_addr", 32'h0, fetch_addr);
            main_errs++;
        end
        finish_test(40, 0);

        // tight limit, so the pair rate is checked too.
        run_test("straight-line flow", 32'h1000, 32, 22, 1'b0, 0);
        run_test("backward and forward branches", 32'h2000, 40, 200, 1'b0, 0);
        set_allow_mode(2);
        run_test("back-pressure", 32'h2000, 120, 3000, 1'b0, 0);

        // stale entries pile up, then the redirect has to drop them.
        set_allow_mode(0);
        redirect_to(32'h1000);
        repeat (12) @(posedge clk);
        set_allow_mode(1);
        run_test("redirect flush", 32'h4000, 24, 100, 1'b0, 0);

        run_test("misaligned redirect", 32'h5002, 1, 40, 1'b1, 30);
        run_test("restart after misaligned", 32'h5000, 16, 60, 1'b0, 0);

        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* frontend_top.f */
fe_pkg.sv
fetch_unit.sv
ibuf.sv
issue_stage.sv
frontend_top.sv
tb_frontend.sv

/* run.sh */
#!/bin/sh
# build and run the frontend testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    --top-module tb_frontend -f frontend_top.f -o sim_frontend

./obj_dir/sim_frontend | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
